//--- Makefile
TOP = tbFpRounder

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f verilog.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir

//--- common/fpFormatPkg.sv
// double and single only; single rides in the double fields and normFrac arrives MSB-aligned
`default_nettype none

package fpFormatPkg;

  //////////////////////////////////////////////////////////////////////
  // format widths
  //////////////////////////////////////////////////////////////////////

  localparam int expWidth      = 11;  // double exponent, single uses the same field
  localparam int fracWidth     = 52;  // double fraction
  localparam int fracWidthS    = 23;  // single fraction
  localparam int intWidth      = 64;  // integer result of a conversion
  localparam int normFracWidth = 72;  // normalized fraction from the normalizer

  // LSB position of each result inside normFrac
  // guard sits one bit below, round two bits below
  localparam int dblLsbPos = normFracWidth - fracWidth;   // 20
  localparam int sglLsbPos = normFracWidth - fracWidthS;  // 49
  localparam int intLsbPos = normFracWidth - intWidth;    // 8

  // single LSB inside the truncated double-width fraction
  localparam int sglIncPos = fracWidth - fracWidthS;      // 29

  //////////////////////////////////////////////////////////////////////
  // format types
  //////////////////////////////////////////////////////////////////////

  typedef enum logic {
    fmtSingle = 1'b0,
    fmtDouble = 1'b1
  } fmtT;

  typedef logic [expWidth-1:0]      expT;      // result exponent
  typedef logic [expWidth+1:0]      wideExpT;  // msb is sign, next is overflow
  typedef logic [expWidth:0]        cvtExpT;   // convert exponent with its sign bit
  typedef logic [fracWidth-1:0]     fracT;
  typedef logic [normFracWidth-1:0] normFracT;

endpackage

`default_nettype wire

//--- common/roundCtrlPkg.sv
// reserved rounding modes 5..7 are legal inputs and give no increment
`default_nettype none

package roundCtrlPkg;

  //////////////////////////////////////////////////////////////////////
  // rounding control
  //////////////////////////////////////////////////////////////////////

  // same encoding as the frm field
  typedef enum logic [2:0] {
    rne = 3'd0,  // nearest, ties to even
    rtz = 3'd1,  // toward zero
    rdn = 3'd2,  // toward minus infinity
    rup = 3'd3,  // toward plus infinity
    rmm = 3'd4   // nearest, ties away from zero
  } roundModeT;

  // which unit produced the operand being rounded
  typedef enum logic [1:0] {
    srcCvt = 2'd0,
    srcDiv = 2'd1,
    srcFma = 2'd2
  } resultSrcT;

endpackage

`default_nettype wire

//--- rounder/roundDecide.sv
// combinational only; integer results assume intWidth is wider than both fraction widths
`timescale 1ns/1ps
`default_nettype none

module roundDecide import fpFormatPkg::*, roundCtrlPkg::*; (
  input  fmtT       outFmt,           // double or single result
  input  roundModeT roundMode,
  input  resultSrcT resultSrc,
  input  logic      toInt,            // convert to integer
  input  logic      sign,             // normalized sign
  input  normFracT  normFrac,
  input  logic      fmaExpTop,        // fma exponent sign, set on deep underflow
  input  logic      fmaAddendSticky,
  input  logic      divSticky,
  input  logic      cvtUf,
  output logic      sticky,
  output logic      guard,
  output logic      roundBit,
  output logic      plus1,            // increment decision
  output logic      ufPlus1,          // increment at unbounded exponent, for the uf flag
  output logic      fracPlus1         // increment that reaches the fraction
);

  logic fmaOp;
  logic divOp;
  logic cvtOp;
  logic intRes;       // integer result of a conversion
  logic fpRes;
  logic isSingle;
  logic normSticky;   // sticky from the fraction bits alone
  logic lsbRes;       // lsb of the kept result
  logic calcPlus1;
  logic ufCalcPlus1;

  assign fmaOp = (resultSrc == srcFma);
  assign divOp = (resultSrc == srcDiv);
  assign cvtOp = (resultSrc == srcCvt);

  assign intRes   = toInt & cvtOp;
  assign fpRes    = ~intRes;
  assign isSingle = (outFmt == fmtSingle);

  //////////////////////////////////////////////////////////////////////
  // sticky
  //////////////////////////////////////////////////////////////////////

  //  | single |  double  |   int   |
  //           ^ band 1   ^ band 2  ^ band 3
  // each band starts at the round bit of the narrower result
  assign normSticky = ((|normFrac[sglLsbPos-2:dblLsbPos-1]) & fpRes & isSingle) |
                      ((|normFrac[dblLsbPos-2:intLsbPos-1]) & fpRes) |
                      (|normFrac[intLsbPos-2:0]);

  // fma shifts everything out on underflow, so the exponent sign is sticky too
  assign sticky = normSticky |
                  (fmaAddendSticky & fmaOp) |
                  (fmaExpTop & fmaOp) |
                  (divSticky & divOp) |
                  (cvtUf & cvtOp);

  //////////////////////////////////////////////////////////////////////
  // guard, round and lsb
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (intRes) begin
      lsbRes   = normFrac[intLsbPos];
      guard    = normFrac[intLsbPos-1];
      roundBit = normFrac[intLsbPos-2];
    end else if (isSingle) begin
      lsbRes   = normFrac[sglLsbPos];
      guard    = normFrac[sglLsbPos-1];
      roundBit = normFrac[sglLsbPos-2];
    end else begin
      lsbRes   = normFrac[dblLsbPos];
      guard    = normFrac[dblLsbPos-1];
      roundBit = normFrac[dblLsbPos-2];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // plus one decisions
  //////////////////////////////////////////////////////////////////////

  // ufCalcPlus1 looks one bit lower, round acts as guard
  always_comb begin
    case (roundMode)
      rne: begin
        calcPlus1   = guard & (roundBit | sticky | lsbRes);  // tie goes to even
        ufCalcPlus1 = roundBit & (sticky | guard);
      end
      rtz: begin
        calcPlus1   = 1'b0;
        ufCalcPlus1 = 1'b0;
      end
      rdn: begin
        calcPlus1   = sign;   // magnitude grows only when negative
        ufCalcPlus1 = sign;
      end
      rup: begin
        calcPlus1   = ~sign;
        ufCalcPlus1 = ~sign;
      end
      rmm: begin
        calcPlus1   = guard;  // tie away from zero
        ufCalcPlus1 = roundBit;
      end
      default: begin
        calcPlus1   = 1'b0;   // reserved mode
        ufCalcPlus1 = 1'b0;
      end
    endcase
  end

  // an exact result is never rounded
  assign plus1   = calcPlus1 & (sticky | roundBit | guard);
  assign ufPlus1 = ufCalcPlus1 & (sticky | roundBit);

  // integer results are rounded downstream, keep the fraction untouched
  assign fracPlus1 = plus1 & ~intRes;

endmodule

`default_nettype wire

//--- rounder/roundResult.sv
// single register stage, no back-pressure; a result shows for exactly one cycle
`timescale 1ns/1ps
`default_nettype none

module roundResult import fpFormatPkg::*, roundCtrlPkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      inValid,
  input  fmtT       outFmt,
  input  resultSrcT resultSrc,
  input  normFracT  normFrac,
  input  wideExpT   fmaExp,
  input  wideExpT   divExp,
  input  cvtExpT    cvtExp,
  input  logic      cvtSubnormUf,  // convert result subnormal or underflowed
  input  logic      cvtUf,         // convert result underflowed
  input  logic      sticky,
  input  logic      guard,
  input  logic      roundBit,
  input  logic      plus1,
  input  logic      ufPlus1,
  input  logic      fracPlus1,
  output logic      outValid,
  output expT       resExp,
  output wideExpT   fullExp,       // with sign and overflow bits
  output fracT      resFrac,
  output logic      stickyOut,
  output logic      guardOut,
  output logic      roundOut,
  output logic      plus1Out,
  output logic      ufPlus1Out
);

  wideExpT selExp;     // exponent of the chosen source
  fracT    truncFrac;  // top fraction bits, before the increment
  fracT    roundAdd;   // increment at the format lsb
  wideExpT sumExp;
  fracT    sumFrac;

  //////////////////////////////////////////////////////////////////////
  // exponent select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (resultSrc)
      srcFma: selExp = fmaExp;
      srcDiv: selExp = divExp;
      srcCvt: begin
        // subnormal convert result keeps a zero exponent
        if (cvtSubnormUf && !cvtUf) begin
          selExp = '0;
        end else begin
          selExp = {cvtExp[expWidth], cvtExp};  // sign extend
        end
      end
      default: selExp = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // increment and add
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    roundAdd            = '0;
    roundAdd[0]         = fracPlus1 & (outFmt == fmtDouble);
    roundAdd[sglIncPos] = fracPlus1 & (outFmt == fmtSingle);  // single lsb
  end

  assign truncFrac = normFrac[normFracWidth-1 -: fracWidth];

  // fraction carry ripples straight into the exponent
  assign {sumExp, sumFrac} = {selExp, truncFrac} + {{(expWidth+2){1'b0}}, roundAdd};

  always_ff @(posedge clk) begin
    if (reset) begin
      outValid   <= 1'b0;
      resExp     <= '0;
      fullExp    <= '0;
      resFrac    <= '0;
      stickyOut  <= 1'b0;
      guardOut   <= 1'b0;
      roundOut   <= 1'b0;
      plus1Out   <= 1'b0;
      ufPlus1Out <= 1'b0;
    end else begin
      outValid   <= inValid;
      resExp     <= sumExp[expWidth-1:0];  // drop sign and overflow
      fullExp    <= sumExp;
      resFrac    <= sumFrac;
      stickyOut  <= sticky;                // flags go on for the flag logic
      guardOut   <= guard;
      roundOut   <= roundBit;
      plus1Out   <= plus1;
      ufPlus1Out <= ufPlus1;
    end
  end

endmodule

`default_nettype wire

//--- source/fpRounder.sv
// latency 1 cycle, one operation per cycle; outputs are lost if not taken that cycle
`timescale 1ns/1ps
`default_nettype none

module fpRounder import fpFormatPkg::*, roundCtrlPkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      inValid,
  input  fmtT       outFmt,
  input  roundModeT roundMode,
  input  resultSrcT resultSrc,
  input  logic      toInt,
  input  logic      sign,
  input  normFracT  normFrac,
  input  wideExpT   fmaExp,
  input  logic      fmaAddendSticky,
  input  wideExpT   divExp,
  input  logic      divSticky,
  input  cvtExpT    cvtExp,
  input  logic      cvtSubnormUf,
  input  logic      cvtUf,
  output logic      outValid,
  output expT       resExp,
  output wideExpT   fullExp,
  output fracT      resFrac,
  output logic      sticky,
  output logic      guard,
  output logic      roundBit,
  output logic      plus1,
  output logic      ufPlus1
);

  // decide to result, same cycle
  logic stickyC;
  logic guardC;
  logic roundC;
  logic plus1C;
  logic ufPlus1C;
  logic fracPlus1C;

  //////////////////////////////////////////////////////////////////////
  // rounding decision
  //////////////////////////////////////////////////////////////////////

  roundDecide u_roundDecide (
    .outFmt          (outFmt),
    .roundMode       (roundMode),
    .resultSrc       (resultSrc),
    .toInt           (toInt),
    .sign            (sign),
    .normFrac        (normFrac),
    .fmaExpTop       (fmaExp[expWidth+1]),  // exponent sign
    .fmaAddendSticky (fmaAddendSticky),
    .divSticky       (divSticky),
    .cvtUf           (cvtUf),
    .sticky          (stickyC),
    .guard           (guardC),
    .roundBit        (roundC),
    .plus1           (plus1C),
    .ufPlus1         (ufPlus1C),
    .fracPlus1       (fracPlus1C)
  );

  //////////////////////////////////////////////////////////////////////
  // result and output register
  //////////////////////////////////////////////////////////////////////

  roundResult u_roundResult (
    .clk          (clk),
    .reset        (reset),
    .inValid      (inValid),
    .outFmt       (outFmt),
    .resultSrc    (resultSrc),
    .normFrac     (normFrac),
    .fmaExp       (fmaExp),
    .divExp       (divExp),
    .cvtExp       (cvtExp),
    .cvtSubnormUf (cvtSubnormUf),
    .cvtUf        (cvtUf),
    .sticky       (stickyC),
    .guard        (guardC),
    .roundBit     (roundC),
    .plus1        (plus1C),
    .ufPlus1      (ufPlus1C),
    .fracPlus1    (fracPlus1C),
    .outValid     (outValid),
    .resExp       (resExp),
    .fullExp      (fullExp),
    .resFrac      (resFrac),
    .stickyOut    (sticky),
    .guardOut     (guard),
    .roundOut     (roundBit),
    .plus1Out     (plus1),
    .ufPlus1Out   (ufPlus1)
  );

endmodule

`default_nettype wire

//--- tb/roundVectors.svh
// rows derived by hand from the rounding rules; exponents of unselected sources hold junk values
`ifndef roundVectorsSvh
`define roundVectorsSvh

// one operation and its expected result
typedef struct packed {
  fmtT       outFmt;
  roundModeT roundMode;
  resultSrcT resultSrc;
  logic      toInt;
  logic      sign;
  normFracT  normFrac;
  logic      fmaAddendSticky;
  logic      divSticky;
  logic      cvtSubnormUf;
  logic      cvtUf;
  wideExpT   fmaExp;
  wideExpT   divExp;
  cvtExpT    cvtExp;
  wideExpT   wantExp;      // expected fullExp
  fracT      wantFrac;     // expected resFrac
  logic      wantPlus1;
  logic      wantUfPlus1;
  logic      wantSticky;
  logic      wantGuard;
  logic      wantRound;
} vecT;

localparam int numVecs = 21;

// line 1: fmt, mode, src, toInt, sign, normFrac, addend/div sticky, subnormUf, uf
// line 2: fma/div/cvt exponent, then fullExp, resFrac, plus1, ufPlus1, sticky, guard, round
localparam vecT vecTable [numVecs] = '{
  // double tie with guard only, every mode
  '{fmtDouble, rne, srcFma, 1'b0, 1'b0, 72'h80_0000_0000_0008_0000, 1'b0, 1'b0, 1'b0, 1'b0,
    13'h03ff, 13'h00aa, 12'h055, 13'h03ff, 52'h8_0000_0000_0000, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0},
  '{fmtDouble, rne, srcFma, 1'b0, 1'b0, 72'h80_0000_0000_0018_0000, 1'b0, 1'b0, 1'b0, 1'b0,
    13'h03ff, 13'h00aa, 12'h055, 13'h03ff, 52'h8_0000_0000_0002, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0},
  '{fmtDouble, rmm, srcFma, 1'b0, 1'b0, 72'h80_0000_0000_0008_0000, 1'b0, 1'b0, 1'b0, 1'b0,
    13'h03ff, 13'h00aa, 12'h055, 13'h03ff, 52'h8_0000_0000_0001, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0},
  '{fmtDouble, rtz, srcFma, 1'b0, 1'b0, 72'h80_0000_0000_0008_0000, 1'b0, 1'b0, 1'b0, 1'b0,
    13'h03ff, 13'h00aa, 12'h055, 13'h03ff, 52'h8_0000_0000_0000, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0},
  '{fmtDouble, rdn, srcFma, 1'b0, 1'b0, 72'h80_0000_0000_0008_0000, 1'b0, 1'b0, 1'b0, 1'b0,
    13'h03ff, 13'h00aa, 12'h055, 13'h03ff, 52'h8_0000_0000_0000, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0},
  '{fmtDouble, rdn, srcFma, 1'b0, 1'b1, 72'h80_0000_0000_0008_0000, 1'b0, 1'b0, 1'b0, 1'b0,
    13'h03ff, 13'h00aa, 12'h055, 13'h03ff, 52'h8_0000_0000_0001, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0},
  '{fmtDouble, rup, srcFma, 1'b0, 1'b0, 72'h80_0000_0000_0008_0000, 1'b0, 1'b0, 1'b0, 1'b0,
    13'h03ff, 13'h00aa, 12'h055, 13'h03ff, 52'h8_0000_0000_0001, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0},
  '{fmtDouble, rup, srcFma, 1'b0, 1'b1, 72'h80_0000_0000_0008_0000, 1'b0, 1'b0, 1'b0, 1'b0,
    13'h03ff, 13'h00aa, 12'h055, 13'h03ff, 52'h8_0000_0000_0000, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0},
  // exact, rup would otherwise round up
  '{fmtDouble, rup, srcFma, 1'b0, 1'b0, 72'h80_0000_0000_0010_0000, 1'b0, 1'b0, 1'b0, 1'b0,
    13'h03ff, 13'h00aa, 12'h055, 13'h03ff, 52'h8_0000_0000_0001, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
  // bit 30 is sticky for single only, single increment lands on fraction bit 29
  '{fmtSingle, rup, srcFma, 1'b0, 1'b0, 72'h80_0000_0000_4000_0000, 1'b0, 1'b0, 1'b0, 1'b0,
    13'h03ff, 13'h00aa, 12'h055, 13'h03ff, 52'h8_0000_2000_0400, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0},
  '{fmtDouble, rup, srcFma, 1'b0, 1'b0, 72'h80_0000_0000_4000_0000, 1'b0, 1'b0, 1'b0, 1'b0,
    13'h03ff, 13'h00aa, 12'h055, 13'h03ff, 52'h8_0000_0000_0400, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
  '{fmtSingle, rne, srcFma, 1'b0, 1'b0, 72'h80_0003_0000_0000_0000, 1'b0, 1'b0, 1'b0, 1'b0,
    13'h03ff, 13'h00aa, 12'h055, 13'h03ff, 52'h8_0000_5000_0000, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0},
  // all ones carries into the exponent
  '{fmtDouble, rne, srcFma, 1'b0, 1'b0, 72'hff_ffff_ffff_fff8_0000, 1'b0, 1'b0, 1'b0, 1'b0,
    13'h03fe, 13'h00aa, 12'h055, 13'h03ff, 52'h0_0000_0000_0000, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0},
  // source select, fma and divide stickies
  '{fmtDouble, rup, srcFma, 1'b0, 1'b0, 72'h80_0000_0000_0000_0000, 1'b1, 1'b0, 1'b0, 1'b0,
    13'h0400, 13'h00aa, 12'h055, 13'h0400, 52'h8_0000_0000_0001, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0},
  '{fmtDouble, rdn, srcDiv, 1'b0, 1'b1, 72'h80_0000_0000_0000_0000, 1'b1, 1'b1, 1'b0, 1'b0,
    13'h1555, 13'h03c0, 12'h055, 13'h03c0, 52'h8_0000_0000_0001, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0},
  // convert, negative exponent, subnormal, underflow
  '{fmtDouble, rne, srcCvt, 1'b0, 1'b0, 72'h80_0000_0000_0000_0000, 1'b1, 1'b1, 1'b0, 1'b0,
    13'h1fff, 13'h0aaa, 12'h801, 13'h1801, 52'h8_0000_0000_0000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
  '{fmtDouble, rne, srcCvt, 1'b0, 1'b0, 72'h80_0000_0000_0000_0000, 1'b0, 1'b0, 1'b1, 1'b0,
    13'h0555, 13'h0aaa, 12'h123, 13'h0000, 52'h8_0000_0000_0000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
  '{fmtDouble, rup, srcCvt, 1'b0, 1'b0, 72'h80_0000_0000_0000_0000, 1'b0, 1'b0, 1'b1, 1'b1,
    13'h0555, 13'h0aaa, 12'h001, 13'h0001, 52'h8_0000_0000_0001, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0},
  // integer results, fraction never incremented
  '{fmtDouble, rne, srcCvt, 1'b1, 1'b0, 72'h80_0000_0000_0000_0180, 1'b0, 1'b0, 1'b0, 1'b0,
    13'h0555, 13'h0aaa, 12'h03e, 13'h003e, 52'h8_0000_0000_0000, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0},
  '{fmtDouble, rne, srcCvt, 1'b1, 1'b0, 72'h80_0000_0000_0000_0048, 1'b0, 1'b0, 1'b0, 1'b0,
    13'h0555, 13'h0aaa, 12'h03e, 13'h003e, 52'h8_0000_0000_0000, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1},
  '{fmtDouble, rmm, srcCvt, 1'b1, 1'b0, 72'h80_0000_0000_0000_00c0, 1'b0, 1'b0, 1'b0, 1'b0,
    13'h0555, 13'h0aaa, 12'h03e, 13'h003e, 52'h8_0000_0000_0000, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1}
};

`endif

//--- tb/tbFpRounder.sv
// expects exactly one result per operation one cycle later; stops at the first mismatch
`timescale 1ns/1ps
`default_nettype none

module tbFpRounder import fpFormatPkg::*, roundCtrlPkg::*;;

  logic      clk = 1'b0;
  logic      reset;
  logic      inValid;
  fmtT       outFmt;
  roundModeT roundMode;
  resultSrcT resultSrc;
  logic      toInt;
  logic      sign;
  normFracT  normFrac;
  wideExpT   fmaExp;
  logic      fmaAddendSticky;
  wideExpT   divExp;
  logic      divSticky;
  cvtExpT    cvtExp;
  logic      cvtSubnormUf;
  logic      cvtUf;
  logic      outValid;
  expT       resExp;
  wideExpT   fullExp;
  fracT      resFrac;
  logic      sticky;
  logic      guard;
  logic      roundBit;
  logic      plus1;
  logic      ufPlus1;

`include "roundVectors.svh"

  fpRounder u_fpRounder (.*);

  initial begin
    forever #50 clk = ~clk;  // 100 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic stopRun(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkExp(input wideExpT got, input wideExpT want, input string what);
    if (got !== want) begin
      stopRun($sformatf("FAIL at %0t: %s is 0x%h, expected 0x%h", $time, what, got, want));
    end
  endtask

  task automatic checkResExp(input expT got, input expT want, input string what);
    if (got !== want) begin
      stopRun($sformatf("FAIL at %0t: %s is 0x%h, expected 0x%h", $time, what, got, want));
    end
  endtask

  task automatic checkFrac(input fracT got, input fracT want, input string what);
    if (got !== want) begin
      stopRun($sformatf("FAIL at %0t: %s is 0x%h, expected 0x%h", $time, what, got, want));
    end
  endtask

  task automatic checkFlag(input logic got, input logic want, input string what);
    if (got !== want) begin
      stopRun($sformatf("FAIL at %0t: %s is %b, expected %b", $time, what, got, want));
    end
  endtask

  task automatic checkRow(input int row);
    checkExp(fullExp, vecTable[row].wantExp, $sformatf("row %0d fullExp", row));
    checkResExp(resExp, vecTable[row].wantExp[expWidth-1:0], $sformatf("row %0d resExp", row));
    checkFrac(resFrac, vecTable[row].wantFrac, $sformatf("row %0d resFrac", row));
    checkFlag(plus1, vecTable[row].wantPlus1, $sformatf("row %0d plus1", row));
    checkFlag(ufPlus1, vecTable[row].wantUfPlus1, $sformatf("row %0d ufPlus1", row));
    checkFlag(sticky, vecTable[row].wantSticky, $sformatf("row %0d sticky", row));
    checkFlag(guard, vecTable[row].wantGuard, $sformatf("row %0d guard", row));
    checkFlag(roundBit, vecTable[row].wantRound, $sformatf("row %0d roundBit", row));
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic applyRow(input int row);
    inValid         = 1'b1;
    outFmt          = vecTable[row].outFmt;
    roundMode       = vecTable[row].roundMode;
    resultSrc       = vecTable[row].resultSrc;
    toInt           = vecTable[row].toInt;
    sign            = vecTable[row].sign;
    normFrac        = vecTable[row].normFrac;
    fmaExp          = vecTable[row].fmaExp;
    fmaAddendSticky = vecTable[row].fmaAddendSticky;
    divExp          = vecTable[row].divExp;
    divSticky       = vecTable[row].divSticky;
    cvtExp          = vecTable[row].cvtExp;
    cvtSubnormUf    = vecTable[row].cvtSubnormUf;
    cvtUf           = vecTable[row].cvtUf;
  endtask

  // polls on falling edges, a few cycles at most
  task automatic waitResult(input int row);
    int waited;
    waited = 0;
    while (outValid !== 1'b1) begin
      inValid = 1'b0;  // no second copy of the row
      if (waited == 4) begin
        stopRun($sformatf("timeout: outValid never rose for row %0d", row));
      end else begin
        @(negedge clk);
        waited++;
      end
    end
    // latency is fixed at one cycle
    if (waited != 0) begin
      stopRun($sformatf("result for row %0d came %0d cycles late", row, waited));
    end
  endtask

  initial begin
    void'($urandom(32'hc472c83f));
    applyRow(0);      // every input gets a known value, valid held through reset
    reset   = 1'b1;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    checkFlag(outValid, 1'b0, "outValid after reset");
    checkExp(fullExp, '0, "fullExp after reset");
    checkFrac(resFrac, '0, "resFrac after reset");
    for (int i = 0; i < numVecs; i++) begin
      applyRow(i);
      @(negedge clk);  // registered at the rising edge in between
      waitResult(i);
      checkRow(i);
      inValid = 1'b0;
      if ($urandom_range(1, 0) != 0) begin
        @(negedge clk);  // idle cycle, otherwise next row goes back-to-back
        checkFlag(outValid, 1'b0, $sformatf("outValid idle after row %0d", i));
      end
    end
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+tb
common/fpFormatPkg.sv
common/roundCtrlPkg.sv
rounder/roundDecide.sv
rounder/roundResult.sv
source/fpRounder.sv
tb/tbFpRounder.sv
